//--- project.f
verilog/cache_pkg.sv
verilog/cache_tag_stage.sv
verilog/cache_data_stage.sv
verilog/cache_miss_unit.sv
verilog/cache_bank.sv
tests/tb_clock_gen.sv
tests/tb_mem_model.sv
tests/cache_bank_tb.sv

//--- Bender.yml
package:
  name: cache_bank

sources:
  # Package first, then the stages, then the top level
  - target: rtl
    files:
      - verilog/cache_pkg.sv
      - verilog/cache_tag_stage.sv
      - verilog/cache_data_stage.sv
      - verilog/cache_miss_unit.sv
      - verilog/cache_bank.sv

  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_mem_model.sv
      - tests/cache_bank_tb.sv

//--- tests/cache_bank_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_bank_tb;
  import cache_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int SEED       = 85567;
  localparam int RAND_OPS   = 200;
  // Directed operations plus the random run
  localparam int NUM_OPS    = 14 + RAND_OPS;
  localparam logic [SRC_W-1:0] BANK = 4'd5;
  localparam logic [ADDR_W-1:0] ADDR_A = 15'h0405;
  localparam logic [ADDR_W-1:0] ADDR_B = 15'h0817;

  logic       clk;
  logic       reset;
  logic       req_valid;
  cache_req_t req;
  logic       req_ready;
  logic       rsp_valid;
  cache_rsp_t rsp;
  logic       mem_req_valid;
  mem_req_t   mem_req;
  logic       mem_req_ready;
  logic       fill_valid;
  logic [LINE_W-1:0] fill_data;
  int         read_count;
  int         write_count;
  mem_req_t   last_read;
  mem_req_t   last_write;

  // Memory contents as seen through the cache
  logic [7:0] shadow [0:(1 << ADDR_W) - 1];
  cache_rsp_t exp_q [$];
  cache_rsp_t exp_rsp;
  cache_rsp_t last_rsp;
  int         errors = 0;
  int         rsp_count = 0;
  int         cycle = 0;
  int         accept_edge;
  int         last_rsp_edge = 0;
  int         prev_rsp_edge = 0;
  int         rnd;

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (4)
  ) u_clk (
    .clk   (clk),
    .reset (reset)
  );

  cache_bank #(
    .BANK_ID (BANK)
  ) uut (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .mem_req_ready (mem_req_ready),
    .fill_valid    (fill_valid),
    .fill_data     (fill_data),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req)
  );

  tb_mem_model u_mem (
    .clk           (clk),
    .reset         (reset),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .fill_valid    (fill_valid),
    .fill_data     (fill_data),
    .read_count    (read_count),
    .write_count   (write_count),
    .last_read     (last_read),
    .last_write    (last_write)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic report_mismatch(input string name, input logic [LINE_W-1:0] exp,
                                 input logic [LINE_W-1:0] act);
    errors++;
    $display("Fail %s: expected %0h, got %0h at %0t", name, exp, act, $time);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error: %s at %0t", msg, $time);
  endtask

  function automatic logic [LINE_W-1:0] shadow_line(input logic [ADDR_W-1:0] addr);
    logic [LINE_W-1:0] line;
    logic [ADDR_W-1:0] base;
    base = {addr[ADDR_W-1:4], 4'h0};
    for (int b = 0; b < LINE_BYTES; b++) begin
      line[b*8 +: 8] = shadow[base + b];
    end
    return line;
  endfunction

  function automatic logic [LINE_W-1:0] random_line();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // Address of eviction tag n in set 3
  function automatic logic [ADDR_W-1:0] evict_addr(input int n);
    return {TAG_W'(32'h20 + n), 2'd3, 4'h0};
  endfunction

  // Called and left 2 ns after a rising edge
  task automatic issue_req(input cache_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [LINE_W-1:0] data, input logic [LINE_BYTES-1:0] mask);
    cache_rsp_t        exp;
    logic [LINE_W-1:0] line;
    logic [ADDR_W-1:0] base;
    req_valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.data  = data;
    req.mask  = mask;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    req_valid   = 1'b0;
    accept_edge = cycle;
    base = {addr[ADDR_W-1:4], 4'h0};
    line = shadow_line(addr);
    if (op == OP_WRITE) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (mask[b]) begin
          line[b*8 +: 8]  = data[b*8 +: 8];
          shadow[base + b] = data[b*8 +: 8];
        end
      end
    end
    exp.op   = op;
    exp.addr = addr;
    exp.data = line;
    exp_q.push_back(exp);
  endtask

  task automatic wait_idle(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("no response for the request to address %0h", exp_q[0].addr));
      exp_q.delete();
    end
  endtask

  // Responses are checked mid-cycle in arrival order
  always @(negedge clk) begin
    if (!reset && rsp_valid) begin
      prev_rsp_edge = last_rsp_edge;
      last_rsp_edge = cycle + 1;
      last_rsp = rsp;
      rsp_count++;
      if (exp_q.size() == 0) begin
        report_error($sformatf("response for address %0h with no request waiting", rsp.addr));
      end else begin
        exp_rsp = exp_q.pop_front();
        if (rsp.addr !== exp_rsp.addr) begin
          report_mismatch("rsp.addr", exp_rsp.addr, rsp.addr);
        end
        if (rsp.op !== exp_rsp.op) begin
          report_mismatch("rsp.op", exp_rsp.op, rsp.op);
        end
        if (rsp.data !== exp_rsp.data) begin
          report_mismatch("rsp.data", exp_rsp.data, rsp.data);
        end
      end
    end
  end

  task automatic check_reset();
    int rc;
    if (req_ready !== 1'b1) begin
      report_mismatch("req_ready", 1, req_ready);
    end
    if (rsp_valid !== 1'b0) begin
      report_mismatch("rsp_valid", 0, rsp_valid);
    end
    if (mem_req_valid !== 1'b0) begin
      report_mismatch("mem_req_valid", 0, mem_req_valid);
    end
    rc = read_count;
    issue_req(OP_READ, ADDR_A, '0, '0);
    wait_idle(100);
    if (read_count != rc + 1) begin
      report_mismatch("read count", rc + 1, read_count);
    end
    if (last_read.op !== MEM_READ) begin
      report_mismatch("mem_req.op", MEM_READ, last_read.op);
    end
    if (last_read.addr !== {ADDR_A[ADDR_W-1:4], 4'h0}) begin
      report_mismatch("mem_req.addr", {ADDR_A[ADDR_W-1:4], 4'h0}, last_read.addr);
    end
    if (last_read.src !== BANK) begin
      report_mismatch("mem_req.src", BANK, last_read.src);
    end
  endtask

  task automatic check_hit_pipeline();
    int first_accept;
    issue_req(OP_READ, ADDR_B, '0, '0);
    wait_idle(100);
    issue_req(OP_READ, ADDR_A, '0, '0);
    wait_idle(100);
    if (last_rsp_edge - accept_edge != 2) begin
      report_mismatch("rsp_valid latency", 2, last_rsp_edge - accept_edge);
    end
    issue_req(OP_READ, ADDR_A, '0, '0);
    first_accept = accept_edge;
    issue_req(OP_READ, ADDR_B, '0, '0);
    wait_idle(100);
    if (accept_edge != first_accept + 1) begin
      report_error("back-to-back hits were not accepted on consecutive edges");
    end
    if (last_rsp_edge != prev_rsp_edge + 1) begin
      report_error("back-to-back hits did not respond on consecutive cycles");
    end
    if (last_rsp_edge - accept_edge != 2) begin
      report_mismatch("rsp_valid latency", 2, last_rsp_edge - accept_edge);
    end
  endtask

  task automatic check_write_merge();
    int rc;
    int wc;
    logic [LINE_W-1:0] merged;
    rc = read_count;
    wc = write_count;
    issue_req(OP_WRITE, ADDR_B, random_line(), LINE_BYTES'($urandom()));
    merged = shadow_line(ADDR_B);
    wait_idle(100);
    issue_req(OP_READ, ADDR_B, '0, '0);
    wait_idle(100);
    if (last_rsp.data !== merged) begin
      report_mismatch("rsp.data", merged, last_rsp.data);
    end
    if (read_count != rc || write_count != wc) begin
      report_error("memory request issued for a resident line");
    end
  endtask

  task automatic check_eviction();
    int wc;
    logic [LINE_W-1:0] written;
    wc = write_count;
    issue_req(OP_WRITE, evict_addr(0), random_line(), LINE_BYTES'($urandom()) | 16'h1);
    written = shadow_line(evict_addr(0));
    wait_idle(100);
    for (int n = 1; n <= 3; n++) begin
      issue_req(OP_READ, evict_addr(n), '0, '0);
    end
    wait_idle(300);
    if (write_count != wc) begin
      report_error("writeback issued while free ways were left in the set");
    end
    // Fourth new tag pushes out the written line
    issue_req(OP_READ, evict_addr(4), '0, '0);
    wait_idle(100);
    if (write_count != wc + 1) begin
      report_mismatch("writeback count", wc + 1, write_count);
    end
    if (last_write.op !== MEM_WRITE) begin
      report_mismatch("mem_req.op", MEM_WRITE, last_write.op);
    end
    if (last_write.addr !== evict_addr(0)) begin
      report_mismatch("mem_req.addr", evict_addr(0), last_write.addr);
    end
    if (last_write.data !== written) begin
      report_mismatch("mem_req.data", written, last_write.data);
    end
    if (last_write.src !== BANK) begin
      report_mismatch("mem_req.src", BANK, last_write.src);
    end
    issue_req(OP_READ, evict_addr(5), '0, '0);
    wait_idle(100);
    if (write_count != wc + 1) begin
      report_error("eviction of a clean line produced a MEM_WRITE");
    end
    issue_req(OP_READ, evict_addr(0), '0, '0);
    wait_idle(100);
    if (last_rsp.data !== written) begin
      report_mismatch("rsp.data", written, last_rsp.data);
    end
  endtask

  // Eight tags per set keep both hits and dirty evictions frequent
  task automatic check_random();
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < RAND_OPS; i++) begin
      addr = {TAG_W'($urandom_range(0, 7)), SET_W'($urandom_range(0, 3)),
              OFFSET_W'($urandom_range(0, 15))};
      if ($urandom_range(0, 1) == 1) begin
        issue_req(OP_WRITE, addr, random_line(), LINE_BYTES'($urandom()));
      end else begin
        issue_req(OP_READ, addr, '0, '0);
      end
    end
    wait_idle(500);
  endtask

  initial begin
    rnd = $urandom(SEED);
    req_valid = 1'b0;
    req = '0;
    // Same initial pattern as the memory model
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      shadow[i] = 8'(i * 3 + 1) ^ 8'(i >> 8);
    end
    @(negedge reset);
    @(posedge clk);
    #2;
    check_reset();
    check_hit_pipeline();
    check_write_merge();
    check_eviction();
    check_random();
    $display("Errors: %0d, responses checked: %0d", errors, rsp_count);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Generous budget of 60 cycles per operation
  initial begin
    #(NUM_OPS * 60 * CLK_PERIOD);
    errors++;
    $display("Watchdog expired with the tests still running at %0t", $time);
    $display("Errors: %0d, responses checked: %0d", errors, rsp_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         mem_req_valid,
  input  cache_pkg::mem_req_t          mem_req,
  output logic                         mem_req_ready,
  output logic                         fill_valid,
  output logic [cache_pkg::LINE_W-1:0] fill_data,
  output int                           read_count,
  output int                           write_count,
  output cache_pkg::mem_req_t          last_read,
  output cache_pkg::mem_req_t          last_write
);
  import cache_pkg::*;

  logic [7:0] mem [0:(1 << ADDR_W) - 1];
  mem_req_t   cur;
  int         lat;

  // Upper address bits folded in so every tag gets its own pattern
  initial begin
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      mem[a] = 8'(a * 3 + 1) ^ 8'(a >> 8);
    end
    mem_req_ready = 1'b0;
    fill_valid    = 1'b0;
    fill_data     = '0;
    read_count    = 0;
    write_count   = 0;
    last_read     = '0;
    last_write    = '0;
  end

  // Ready drops on about one cycle in four
  always begin
    @(posedge clk);
    #2 mem_req_ready = ($urandom_range(0, 3) != 0);
  end

  // Request sampled mid-cycle and transferred on the next edge
  always @(negedge clk) begin
    if (!reset && mem_req_valid && mem_req_ready) begin
      cur = mem_req;
      @(posedge clk);
      if (cur.op == MEM_WRITE) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
          mem[cur.addr + b] = cur.data[b*8 +: 8];
        end
        write_count = write_count + 1;
        last_write  = cur;
      end else begin
        read_count = read_count + 1;
        last_read  = cur;
        lat = $urandom_range(0, 3);
        repeat (lat) @(posedge clk);
        #2;
        for (int b = 0; b < LINE_BYTES; b++) begin
          fill_data[b*8 +: 8] = mem[cur.addr + b];
        end
        fill_valid = 1'b1;
        @(posedge clk);
        #2 fill_valid = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  // Released just after an edge, like the other inputs
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verilog/cache_bank.sv
`timescale 1ns/100ps
`default_nettype none

module cache_bank #(
  parameter logic [cache_pkg::SRC_W-1:0] BANK_ID = '0
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_valid,
  input  cache_pkg::cache_req_t        req,
  input  logic                         mem_req_ready,
  input  logic                         fill_valid,
  input  logic [cache_pkg::LINE_W-1:0] fill_data,
  output logic                         req_ready,
  output logic                         rsp_valid,
  output cache_pkg::cache_rsp_t        rsp,
  output logic                         mem_req_valid,
  output cache_pkg::mem_req_t          mem_req
);
  import cache_pkg::*;

  logic              hit_valid;
  tag_hit_t          hit;
  logic              miss_valid;
  miss_info_t        miss;
  logic              miss_busy;
  logic              victim_rd;
  logic [SET_W-1:0]  victim_set;
  logic [WAY_W-1:0]  victim_way;
  logic [LINE_W-1:0] victim_line;
  logic              fill_wr;
  logic [SET_W-1:0]  fill_set;
  logic [WAY_W-1:0]  fill_way;
  logic [LINE_W-1:0] fill_line;

  cache_tag_stage u_tag (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .miss_busy  (miss_busy),
    .fill_wr    (fill_wr),
    .fill_set   (fill_set),
    .fill_way   (fill_way),
    .req_ready  (req_ready),
    .hit_valid  (hit_valid),
    .hit        (hit),
    .miss_valid (miss_valid),
    .miss       (miss)
  );

  cache_data_stage u_data (
    .clk         (clk),
    .reset       (reset),
    .hit_valid   (hit_valid),
    .hit         (hit),
    .victim_rd   (victim_rd),
    .victim_set  (victim_set),
    .victim_way  (victim_way),
    .fill_wr     (fill_wr),
    .fill_set    (fill_set),
    .fill_way    (fill_way),
    .fill_line   (fill_line),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .victim_line (victim_line)
  );

  cache_miss_unit #(
    .BANK_ID (BANK_ID)
  ) u_miss (
    .clk           (clk),
    .reset         (reset),
    .miss_valid    (miss_valid),
    .miss          (miss),
    .victim_line   (victim_line),
    .mem_req_ready (mem_req_ready),
    .fill_valid    (fill_valid),
    .fill_data     (fill_data),
    .miss_busy     (miss_busy),
    .victim_rd     (victim_rd),
    .victim_set    (victim_set),
    .victim_way    (victim_way),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .fill_wr       (fill_wr),
    .fill_set      (fill_set),
    .fill_way      (fill_way),
    .fill_line     (fill_line)
  );

endmodule

`default_nettype wire

//--- verilog/cache_miss_unit.sv
`timescale 1ns/100ps
`default_nettype none

module cache_miss_unit #(
  parameter logic [cache_pkg::SRC_W-1:0] BANK_ID = '0
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         miss_valid,
  input  cache_pkg::miss_info_t        miss,
  input  logic [cache_pkg::LINE_W-1:0] victim_line,
  input  logic                         mem_req_ready,
  input  logic                         fill_valid,
  input  logic [cache_pkg::LINE_W-1:0] fill_data,
  output logic                         miss_busy,
  output logic                         victim_rd,
  output logic [cache_pkg::SET_W-1:0]  victim_set,
  output logic [cache_pkg::WAY_W-1:0]  victim_way,
  output logic                         mem_req_valid,
  output cache_pkg::mem_req_t          mem_req,
  output logic                         fill_wr,
  output logic [cache_pkg::SET_W-1:0]  fill_set,
  output logic [cache_pkg::WAY_W-1:0]  fill_way,
  output logic [cache_pkg::LINE_W-1:0] fill_line
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ_VICTIM,
    WRITEBACK,
    READ_LINE,
    WAIT_FILL,
    FILL
  } state_e;

  state_e     state_q;
  state_e     state_d;
  miss_info_t info_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (miss_valid) begin
          state_d = READ_VICTIM;
        end
      end
      READ_VICTIM: state_d = info_q.victim_dirty ? WRITEBACK : READ_LINE;
      WRITEBACK: begin
        if (mem_req_ready) begin
          state_d = READ_LINE;
        end
      end
      READ_LINE: begin
        if (mem_req_ready) begin
          state_d = WAIT_FILL;
        end
      end
      WAIT_FILL: begin
        if (fill_valid) begin
          state_d = FILL;
        end
      end
      FILL: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && miss_valid) begin
      info_q <= miss;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == WAIT_FILL && fill_valid) begin
      fill_line <= fill_data;
    end
  end

  assign miss_busy  = (state_q != IDLE);
  assign victim_rd  = (state_q == READ_VICTIM);
  assign victim_set = addr_set(info_q.line_addr);
  assign victim_way = info_q.victim_way;
  assign fill_wr    = (state_q == FILL);
  assign fill_set   = addr_set(info_q.line_addr);
  assign fill_way   = info_q.victim_way;

  assign mem_req_valid = (state_q == WRITEBACK) || (state_q == READ_LINE);

  // Data field only matters for the writeback
  always_comb begin
    mem_req.op   = (state_q == WRITEBACK) ? MEM_WRITE : MEM_READ;
    mem_req.addr = (state_q == WRITEBACK) ? info_q.victim_addr : info_q.line_addr;
    mem_req.data = victim_line;
    mem_req.src  = BANK_ID;
  end

  assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else $error("miss unit: memory request changed while stalled");

endmodule

`default_nettype wire

//--- verilog/cache_data_stage.sv
`timescale 1ns/100ps
`default_nettype none

module cache_data_stage (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         hit_valid,
  input  cache_pkg::tag_hit_t          hit,
  input  logic                         victim_rd,
  input  logic [cache_pkg::SET_W-1:0]  victim_set,
  input  logic [cache_pkg::WAY_W-1:0]  victim_way,
  input  logic                         fill_wr,
  input  logic [cache_pkg::SET_W-1:0]  fill_set,
  input  logic [cache_pkg::WAY_W-1:0]  fill_way,
  input  logic [cache_pkg::LINE_W-1:0] fill_line,
  output logic                         rsp_valid,
  output cache_pkg::cache_rsp_t        rsp,
  output logic [cache_pkg::LINE_W-1:0] victim_line
);
  import cache_pkg::*;

  // Line storage, indexed by set then way
  logic [LINE_W-1:0] data_q [NUM_SETS][NUM_WAYS];

  logic [LINE_W-1:0] cur_line;
  logic [LINE_W-1:0] new_line;
  logic              hit_write;

  assign cur_line  = data_q[hit.set][hit.way];
  assign hit_write = hit_valid && hit.set_dirty;

  // Byte b of the line sits at bits 8b+7 down to 8b
  always_comb begin
    new_line = cur_line;
    if (hit.set_dirty) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (hit.req.mask[b]) begin
          new_line[b*8 +: 8] = hit.req.data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_wr) begin
      data_q[fill_set][fill_way] <= fill_line;
    end else if (hit_write) begin
      data_q[hit.set][hit.way] <= new_line;
    end
  end

  // Victim line is ready the cycle after the read
  always_ff @(posedge clk) begin
    if (victim_rd) begin
      victim_line <= data_q[victim_set][victim_way];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= hit_valid;
    end
  end

  // Writes return the line after the merge
  always_ff @(posedge clk) begin
    if (hit_valid) begin
      rsp.op   <= hit.req.op;
      rsp.addr <= hit.req.addr;
      rsp.data <= new_line;
    end
  end

  // Pipeline drains before the miss unit fills
  assert property (@(posedge clk) disable iff (reset) !(fill_wr && hit_valid))
    else $error("data stage: fill collides with a hit");

endmodule

`default_nettype wire

//--- verilog/cache_tag_stage.sv
`timescale 1ns/100ps
`default_nettype none

module cache_tag_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_valid,
  input  cache_pkg::cache_req_t       req,
  input  logic                        miss_busy,
  input  logic                        fill_wr,
  input  logic [cache_pkg::SET_W-1:0] fill_set,
  input  logic [cache_pkg::WAY_W-1:0] fill_way,
  output logic                        req_ready,
  output logic                        hit_valid,
  output cache_pkg::tag_hit_t         hit,
  output logic                        miss_valid,
  output cache_pkg::miss_info_t       miss
);
  import cache_pkg::*;

  // Per-set tag state
  logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
  logic [WAY_W-1:0]    age_q   [NUM_SETS][NUM_WAYS];

  // Stage-one register
  logic       s1_valid;
  cache_req_t s1_req;

  logic [SET_W-1:0]    set_idx;
  logic [TAG_W-1:0]    req_tag;
  logic [NUM_WAYS-1:0] hit_vec;
  logic [WAY_W-1:0]    hit_way;
  logic                s1_hit;
  logic [WAY_W-1:0]    victim_way;
  logic                found_invalid;
  logic                accept;
  logic                touch;
  logic [SET_W-1:0]    touch_set;
  logic [WAY_W-1:0]    touch_way;

  assign set_idx = addr_set(s1_req.addr);
  assign req_tag = addr_tag(s1_req.addr);

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == req_tag);
      if (hit_vec[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  // Lowest invalid way first, otherwise the oldest
  always_comb begin
    found_invalid = 1'b0;
    victim_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found_invalid && !valid_q[set_idx][w]) begin
        found_invalid = 1'b1;
        victim_way = WAY_W'(w);
      end
    end
    if (!found_invalid) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (age_q[set_idx][w] == WAY_W'(NUM_WAYS - 1)) begin
          victim_way = WAY_W'(w);
        end
      end
    end
  end

  assign s1_hit    = s1_valid && (|hit_vec);
  assign req_ready = !s1_valid || s1_hit;
  assign accept    = req_valid && req_ready;

  assign hit_valid     = s1_hit;
  assign hit.req       = s1_req;
  assign hit.set       = set_idx;
  assign hit.way       = hit_way;
  assign hit.set_dirty = (s1_req.op == OP_WRITE);

  assign miss_valid        = s1_valid && !(|hit_vec) && !miss_busy;
  assign miss.line_addr    = line_addr(s1_req.addr);
  assign miss.victim_way   = victim_way;
  assign miss.victim_dirty = dirty_q[set_idx][victim_way];
  assign miss.victim_addr  = {tag_q[set_idx][victim_way], set_idx, {OFFSET_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (accept) begin
      s1_valid <= 1'b1;
    end else if (s1_hit) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_req <= req;
    end
  end

  // Fill installs the held request's tag
  always_ff @(posedge clk) begin
    if (fill_wr) begin
      tag_q[fill_set][fill_way] <= req_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else if (fill_wr) begin
      valid_q[fill_set][fill_way] <= 1'b1;
      dirty_q[fill_set][fill_way] <= 1'b0;
    end else if (s1_hit && hit.set_dirty) begin
      dirty_q[set_idx][hit_way] <= 1'b1;
    end
  end

  // Touched way goes to zero, younger ways grow one older
  assign touch     = fill_wr || s1_hit;
  assign touch_set = fill_wr ? fill_set : set_idx;
  assign touch_way = fill_wr ? fill_way : hit_way;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          age_q[s][w] <= WAY_W'(w);
        end
      end
    end else if (touch) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (WAY_W'(w) == touch_way) begin
          age_q[touch_set][w] <= '0;
        end else if (age_q[touch_set][w] < age_q[touch_set][touch_way]) begin
          age_q[touch_set][w] <= age_q[touch_set][w] + 1'b1;
        end
      end
    end
  end

  // A tag is never installed twice in one set
  assert property (@(posedge clk) disable iff (reset) s1_valid |-> $onehot0(hit_vec))
    else $error("tag stage: more than one way hits");

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // Bank geometry
  localparam int ADDR_W     = 15;
  localparam int LINE_BYTES = 16;
  localparam int LINE_W     = LINE_BYTES * 8;
  localparam int OFFSET_W   = 4;
  localparam int NUM_SETS   = 4;
  localparam int SET_W      = 2;
  localparam int NUM_WAYS   = 4;
  localparam int WAY_W      = 2;
  localparam int TAG_W      = ADDR_W - SET_W - OFFSET_W;
  localparam int SRC_W      = 4;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_e;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef struct packed {
    cache_op_e             op;
    logic [ADDR_W-1:0]     addr;
    logic [LINE_W-1:0]     data;
    logic [LINE_BYTES-1:0] mask;
  } cache_req_t;

  typedef struct packed {
    cache_op_e         op;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] data;
  } cache_rsp_t;

  typedef struct packed {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] data;
    logic [SRC_W-1:0]  src;
  } mem_req_t;

  // Tag stage to data stage
  typedef struct packed {
    cache_req_t       req;
    logic [SET_W-1:0] set;
    logic [WAY_W-1:0] way;
    logic             set_dirty;
  } tag_hit_t;

  // Tag stage to miss unit
  typedef struct packed {
    logic [ADDR_W-1:0] line_addr;
    logic [WAY_W-1:0]  victim_way;
    logic              victim_dirty;
    logic [ADDR_W-1:0] victim_addr;
  } miss_info_t;

  function automatic logic [SET_W-1:0] addr_set(input logic [ADDR_W-1:0] addr);
    return addr[OFFSET_W +: SET_W];
  endfunction

  function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

  // Clears the byte offset
  function automatic logic [ADDR_W-1:0] line_addr(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

endpackage

`default_nettype wire
